/* src/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    // result path sizes
    localparam int XLEN      = 32;
    localparam int ROB_ID_W  = 6;
    localparam int ROB_DEPTH = 64; // one entry per rob id

    localparam int FU_COUNT      = 4; // alu0, alu1, lsu, mdu
    localparam int CDB_COUNT     = 2;
    localparam int RD_PORT_COUNT = 2; // operand reads from dispatch

    localparam int RESULT_FIFO_DEPTH = 2;

    // derived widths
    localparam int FU_SEL_W   = $clog2(FU_COUNT);
    localparam int FIFO_PTR_W = $clog2(RESULT_FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(RESULT_FIFO_DEPTH + 1);
    localparam int SLOT_CNT_W = $clog2(CDB_COUNT + 1);

endpackage

/* src/cdb_pkg.sv */
package cdb_pkg;

    // one finished result as handed over by a functional unit
    typedef struct packed {
        logic [cpu_cfg_pkg::ROB_ID_W-1:0] rob_id;
        logic [cpu_cfg_pkg::XLEN-1:0]     w_data;
    } cdb_info_t;

    // a single slot of the common data bus
    typedef struct packed {
        logic      valid;
        cdb_info_t info;
    } cdb_slot_t;

    // answer of one operand read port
    typedef struct packed {
        logic                         done; // result already written back
        logic [cpu_cfg_pkg::XLEN-1:0] data;
    } operand_resp_t;

endpackage

/* src/fu_result_fifo.sv */
`timescale 1ns/100ps

module fu_result_fifo (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               flush_i,
    input  logic               push_i,
    input  cdb_pkg::cdb_info_t push_data_i,
    output logic               ready_o,
    output logic               head_valid_o,
    output cdb_pkg::cdb_info_t head_o,
    input  logic               pop_i
);

    import cpu_cfg_pkg::*;
    import cdb_pkg::*;

    cdb_info_t mem_q [RESULT_FIFO_DEPTH]; // payload only

    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_CNT_W-1:0] count;

    logic full;
    logic push_ok;
    logic pop_ok;

    assign full    = (count == FIFO_CNT_W'(RESULT_FIFO_DEPTH));
    assign push_ok = push_i & ~full; // push is dropped when full
    assign pop_ok  = pop_i & head_valid_o;

    assign ready_o      = ~full;
    assign head_valid_o = (count != '0);
    assign head_o       = mem_q[rd_ptr]; // no bypass from push side

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            // flush also discards a push at the same edge
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)  rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr] <= push_data_i;
        end
    end

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic                                            clk,
    input  logic                                            arst_n_i,
    input  logic                                            flush_i,
    input  logic [cpu_cfg_pkg::FU_COUNT-1:0]                head_valid_i,
    input  cdb_pkg::cdb_info_t [cpu_cfg_pkg::FU_COUNT-1:0]  head_i,
    output logic [cpu_cfg_pkg::FU_COUNT-1:0]                pop_o,
    output cdb_pkg::cdb_slot_t [cpu_cfg_pkg::CDB_COUNT-1:0] cdb_o
);

    import cpu_cfg_pkg::*;
    import cdb_pkg::*;

    logic [FU_SEL_W-1:0] rr_ptr;   // first queue to look at
    logic [FU_SEL_W-1:0] next_ptr;
    logic [FU_SEL_W-1:0] idx;
    logic [SLOT_CNT_W-1:0] sel_cnt;

    logic [CDB_COUNT-1:0][FU_SEL_W-1:0] sel_idx;
    logic [CDB_COUNT-1:0]               sel_vld;

    logic [CDB_COUNT-1:0] slot_vld_q;
    cdb_info_t            slot_info_q [CDB_COUNT];

    // walk the queues in rotating order, slot 0 gets the first hit
    always_comb begin
        pop_o    = '0;
        sel_idx  = '0;
        sel_vld  = '0;
        sel_cnt  = '0;
        idx      = rr_ptr;
        next_ptr = rr_ptr; // hold when nothing is granted
        for (int i = 0; i < FU_COUNT; i++) begin
            idx = rr_ptr + FU_SEL_W'(i);
            if (head_valid_i[idx] && (sel_cnt < SLOT_CNT_W'(CDB_COUNT))) begin
                sel_idx[sel_cnt[0 +: $clog2(CDB_COUNT)]] = idx;
                sel_vld[sel_cnt[0 +: $clog2(CDB_COUNT)]] = 1'b1;
                pop_o[idx] = 1'b1;
                next_ptr   = idx + 1'b1; // one past the last grant
                sel_cnt    = sel_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr     <= '0;
            slot_vld_q <= '0;
        end else begin
            rr_ptr <= next_ptr;
            if (flush_i) slot_vld_q <= '0; // pointer keeps moving
            else         slot_vld_q <= sel_vld;
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < CDB_COUNT; s++) begin
            if (sel_vld[s]) begin
                slot_info_q[s] <= head_i[sel_idx[s]];
            end
        end
    end

    always_comb begin
        for (int s = 0; s < CDB_COUNT; s++) begin
            cdb_o[s].valid = slot_vld_q[s];
            cdb_o[s].info  = slot_info_q[s];
        end
    end

endmodule

/* src/rob_complete_table.sv */
`timescale 1ns/100ps

module rob_complete_table (
    input  logic                                                    clk,
    input  logic                                                    arst_n_i,
    input  cdb_pkg::cdb_slot_t [cpu_cfg_pkg::CDB_COUNT-1:0]         cdb_i,
    input  logic                                                    alloc_valid_i,
    input  logic [cpu_cfg_pkg::ROB_ID_W-1:0]                        alloc_id_i,
    input  logic [cpu_cfg_pkg::RD_PORT_COUNT-1:0]
                 [cpu_cfg_pkg::ROB_ID_W-1:0]                        rd_id_i,
    output cdb_pkg::operand_resp_t [cpu_cfg_pkg::RD_PORT_COUNT-1:0] rd_resp_o
);

    import cpu_cfg_pkg::*;
    import cdb_pkg::*;

    logic [ROB_DEPTH-1:0] done_q;
    logic [XLEN-1:0]      data_q [ROB_DEPTH];

    // done flags, allocation clears them
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q <= '0;
        end else begin
            for (int s = 0; s < CDB_COUNT; s++) begin
                if (cdb_i[s].valid) begin
                    done_q[cdb_i[s].info.rob_id] <= 1'b1;
                end
            end
            // last assignment, so a new allocation beats a stale write
            if (alloc_valid_i) begin
                done_q[alloc_id_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < CDB_COUNT; s++) begin
            if (cdb_i[s].valid) begin
                data_q[cdb_i[s].info.rob_id] <= cdb_i[s].info.w_data;
            end
        end
    end

    // read ports see this cycle's bus before it is written
    always_comb begin
        for (int p = 0; p < RD_PORT_COUNT; p++) begin
            rd_resp_o[p].done = done_q[rd_id_i[p]];
            rd_resp_o[p].data = data_q[rd_id_i[p]];
            for (int s = 0; s < CDB_COUNT; s++) begin
                if (cdb_i[s].valid && (cdb_i[s].info.rob_id == rd_id_i[p])) begin
                    rd_resp_o[p].done = 1'b1; // forward from bus
                    rd_resp_o[p].data = cdb_i[s].info.w_data;
                end
            end
        end
    end

endmodule

/* src/result_bus_top.sv */
`timescale 1ns/100ps

module result_bus_top (
    input  logic                                                    clk,
    input  logic                                                    arst_n_i,
    input  logic                                                    flush_i,
    // functional unit side
    input  logic [cpu_cfg_pkg::FU_COUNT-1:0]                        fu_valid_i,
    input  cdb_pkg::cdb_info_t [cpu_cfg_pkg::FU_COUNT-1:0]          fu_result_i,
    output logic [cpu_cfg_pkg::FU_COUNT-1:0]                        fu_ready_o,
    // dispatch side
    input  logic                                                    alloc_valid_i,
    input  logic [cpu_cfg_pkg::ROB_ID_W-1:0]                        alloc_id_i,
    input  logic [cpu_cfg_pkg::RD_PORT_COUNT-1:0]
                 [cpu_cfg_pkg::ROB_ID_W-1:0]                        rd_id_i,
    output cdb_pkg::operand_resp_t [cpu_cfg_pkg::RD_PORT_COUNT-1:0] rd_resp_o,
    output cdb_pkg::cdb_slot_t [cpu_cfg_pkg::CDB_COUNT-1:0]         cdb_o
);

    import cpu_cfg_pkg::*;
    import cdb_pkg::*;

    logic [FU_COUNT-1:0]      head_valid;
    cdb_info_t [FU_COUNT-1:0] head;
    logic [FU_COUNT-1:0]      pop;

    // one result queue per unit
    for (genvar i = 0; i < FU_COUNT; i++) begin : g_fu_fifo
        fu_result_fifo u_fifo (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .flush_i      (flush_i),
            .push_i       (fu_valid_i[i]),
            .push_data_i  (fu_result_i[i]),
            .ready_o      (fu_ready_o[i]),
            .head_valid_o (head_valid[i]),
            .head_o       (head[i]),
            .pop_i        (pop[i])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .cdb_o        (cdb_o) // also drives the table write side
    );

    rob_complete_table u_rob_complete_table (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .cdb_i         (cdb_o),
        .alloc_valid_i (alloc_valid_i),
        .alloc_id_i    (alloc_id_i),
        .rd_id_i       (rd_id_i),
        .rd_resp_o     (rd_resp_o)
    );

endmodule

/* sim/result_model.svh */
`ifndef RESULT_MODEL_SVH
`define RESULT_MODEL_SVH

// accepted results per unit, oldest first, until they show up on the bus
cdb_info_t       pending_q [FU_COUNT][$];
logic            shadow_done [ROB_DEPTH];
logic [XLEN-1:0] shadow_data [ROB_DEPTH];

// each unit owns one quarter of the rob ids
function automatic int unit_of(logic [ROB_ID_W-1:0] rob_id);
    return int'(rob_id[ROB_ID_W-1 -: FU_SEL_W]);
endfunction

task automatic clear_model();
    for (int u = 0; u < FU_COUNT; u++) pending_q[u].delete();
    for (int i = 0; i < ROB_DEPTH; i++) begin
        shadow_done[i] = 1'b0;
        shadow_data[i] = '0;
    end
endtask

task automatic drop_pending();
    for (int u = 0; u < FU_COUNT; u++) pending_q[u].delete(); // table stays
endtask

task automatic write_back(cdb_slot_t [CDB_COUNT-1:0] bus);
    for (int s = 0; s < CDB_COUNT; s++) begin
        if (bus[s].valid) begin
            shadow_done[bus[s].info.rob_id] = 1'b1;
            shadow_data[bus[s].info.rob_id] = bus[s].info.w_data;
        end
    end
endtask

task automatic clear_done(logic [ROB_ID_W-1:0] id);
    shadow_done[id] = 1'b0; // called after write_back, so allocation wins
endtask

function automatic operand_resp_t expected_operand(logic [ROB_ID_W-1:0] id,
                                                   cdb_slot_t [CDB_COUNT-1:0] bus);
    operand_resp_t resp;
    resp.done = shadow_done[id];
    resp.data = shadow_data[id];
    for (int s = 0; s < CDB_COUNT; s++) begin
        if (bus[s].valid && (bus[s].info.rob_id == id)) begin
            resp.done = 1'b1; // bus result seen in the same cycle
            resp.data = bus[s].info.w_data;
        end
    end
    return resp;
endfunction

`endif

/* sim/tb_result_bus.sv */
`timescale 1ns/100ps

module tb_result_bus;

    import cpu_cfg_pkg::*;
    import cdb_pkg::*;

    logic                                   clk;
    logic                                   arst_n_i;
    logic                                   flush_i;
    logic [FU_COUNT-1:0]                    fu_valid_i;
    cdb_info_t [FU_COUNT-1:0]               fu_result_i;
    logic [FU_COUNT-1:0]                    fu_ready_o;
    logic                                   alloc_valid_i;
    logic [ROB_ID_W-1:0]                    alloc_id_i;
    logic [RD_PORT_COUNT-1:0][ROB_ID_W-1:0] rd_id_i;
    operand_resp_t [RD_PORT_COUNT-1:0]      rd_resp_o;
    cdb_slot_t [CDB_COUNT-1:0]              cdb_o;

    logic [FU_COUNT-1:0] take;        // handshake seen before the coming edge
    logic [3:0]          seq [FU_COUNT];
    bit                  checking;
    bit                  flush_seen;
    int                  flush_count;
    int                  cycle_count;

    `include "result_model.svh"

    result_bus_top DUT (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .fu_valid_i    (fu_valid_i),
        .fu_result_i   (fu_result_i),
        .fu_ready_o    (fu_ready_o),
        .alloc_valid_i (alloc_valid_i),
        .alloc_id_i    (alloc_id_i),
        .rd_id_i       (rd_id_i),
        .rd_resp_o     (rd_resp_o),
        .cdb_o         (cdb_o)
    );

    always #50 clk = ~clk;

    task automatic stop_with_error();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        stop_with_error();
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
        stop_with_error();
    endtask

    // new offers only once the previous one went through
    task automatic drive_inputs(input bit new_offers);
        for (int u = 0; u < FU_COUNT; u++) begin
            if (!fu_valid_i[u] || take[u]) begin
                if (new_offers && ($urandom % 4 != 0)) begin
                    fu_valid_i[u]  <= 1'b1;
                    fu_result_i[u] <= '{rob_id: {2'(u), seq[u]}, w_data: $urandom};
                    seq[u] = seq[u] + 4'd1;
                end else begin
                    fu_valid_i[u] <= 1'b0;
                end
            end
        end
        alloc_valid_i <= ($urandom % 8 == 0);
        alloc_id_i    <= ROB_ID_W'($urandom % ROB_DEPTH);
        for (int p = 0; p < RD_PORT_COUNT; p++) rd_id_i[p] <= ROB_ID_W'($urandom % ROB_DEPTH);
        if (new_offers && ($urandom % 100 == 0)) begin
            flush_i <= 1'b1; // rare
            flush_count++;
        end else begin
            flush_i <= 1'b0;
        end
    endtask

    task automatic check_cycle();
        operand_resp_t exp_rd;
        int            u;
        if (flush_seen) begin
            assert (!cdb_o[0].valid && !cdb_o[1].valid)
            else report_failure("bus carries a result in the cycle after a flush");
        end
        assert (cdb_o[0].valid || !cdb_o[1].valid)
        else report_failure("slot 1 is valid while slot 0 is empty");
        if (cdb_o[0].valid && cdb_o[1].valid) begin
            assert (unit_of(cdb_o[0].info.rob_id) != unit_of(cdb_o[1].info.rob_id))
            else report_failure("both bus slots carry results of one unit");
        end
        // reads see the table before this cycle's bus writes land
        for (int p = 0; p < RD_PORT_COUNT; p++) begin
            exp_rd = expected_operand(rd_id_i[p], cdb_o);
            assert (rd_resp_o[p].done == exp_rd.done)
            else report_mismatch($sformatf("read done port %0d id %0d", p, rd_id_i[p]),
                                 64'(exp_rd.done), 64'(rd_resp_o[p].done));
            if (exp_rd.done) begin
                assert (rd_resp_o[p].data == exp_rd.data)
                else report_mismatch($sformatf("read data port %0d id %0d", p, rd_id_i[p]),
                                     64'(exp_rd.data), 64'(rd_resp_o[p].data));
            end
        end
        for (int s = 0; s < CDB_COUNT; s++) begin
            if (cdb_o[s].valid) begin
                u = unit_of(cdb_o[s].info.rob_id);
                assert (pending_q[u].size() > 0)
                else report_failure($sformatf("bus slot %0d shows a result unit %0d never had",
                                              s, u));
                assert (pending_q[u][0] == cdb_o[s].info)
                else report_mismatch($sformatf("delivery slot %0d unit %0d", s, u),
                                     64'(pending_q[u][0]), 64'(cdb_o[s].info));
                void'(pending_q[u].pop_front());
            end
        end
        // what is left in the model sits in the queue
        for (int k = 0; k < FU_COUNT; k++) begin
            assert (fu_ready_o[k] == (pending_q[k].size() < RESULT_FIFO_DEPTH))
            else report_mismatch($sformatf("ready unit %0d", k),
                                 64'(pending_q[k].size() < RESULT_FIFO_DEPTH),
                                 64'(fu_ready_o[k]));
        end
        write_back(cdb_o);
        if (alloc_valid_i) clear_done(alloc_id_i);
        for (int k = 0; k < FU_COUNT; k++) begin
            take[k] = fu_valid_i[k] & fu_ready_o[k];
            if (take[k] && !flush_i) pending_q[k].push_back(fu_result_i[k]);
        end
        if (flush_i) drop_pending();
        flush_seen = flush_i;
    endtask

    always @(negedge clk) begin
        if (checking) check_cycle();
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= 2000 + 50 * flush_count) begin
            report_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        void'($urandom(32'h5874));
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        flush_i       = 1'b0;
        fu_valid_i    = '0;
        fu_result_i   = '0;
        alloc_valid_i = 1'b0;
        alloc_id_i    = '0;
        rd_id_i       = '0;
        take          = '0;
        checking      = 1'b0;
        flush_seen    = 1'b0;
        flush_count   = 0;
        cycle_count   = 0;
        for (int u = 0; u < FU_COUNT; u++) seq[u] = '0;
        clear_model();
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        assert (&fu_ready_o)
        else report_mismatch("reset ready", 64'({FU_COUNT{1'b1}}), 64'(fu_ready_o));
        assert (!cdb_o[0].valid && !cdb_o[1].valid)
        else report_failure("bus slot valid right after reset");
        @(posedge clk);
        checking = 1'b1;
        drive_inputs(1'b1);
        repeat (1499) begin
            @(posedge clk);
            drive_inputs(1'b1);
        end
        // stop offering until every unit got its last result accepted
        do begin
            @(posedge clk);
            drive_inputs(1'b0);
        end while (fu_valid_i != '0);
        // full queues empty at two results per cycle plus the bus stage
        repeat (FU_COUNT * RESULT_FIFO_DEPTH / CDB_COUNT + 2) @(posedge clk);
        for (int u = 0; u < FU_COUNT; u++) begin
            assert (pending_q[u].size() == 0)
            else report_mismatch($sformatf("drain unit %0d", u), 64'(0),
                                 64'(pending_q[u].size()));
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* flist.f */
+incdir+sim
src/cpu_cfg_pkg.sv
src/cdb_pkg.sv
src/fu_result_fifo.sv
src/cdb_arbiter.sv
src/rob_complete_table.sv
src/result_bus_top.sv
sim/tb_result_bus.sv

/* Makefile */
# Verilator build and run of the result bus testbench

VERILATOR ?= verilator
TOP       ?= tb_result_bus
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(filter-out +%,$(shell cat $(FLIST)))
HEADERS := $(wildcard sim/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
